//--- hdl/dino_pkg.sv
package dino_pkg;

  //////////////////////////////////////////////////////////////////////
  // pixel and raster types
  //////////////////////////////////////////////////////////////////////

  // one 12-bit pixel, r in the top nibble
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  localparam rgb_t white = '{r: 4'hf, g: 4'hf, b: 4'hf}; // background colour

  // raster control group, hs/vs active low
  typedef struct packed {
    logic hs;
    logic vs;
    logic de; // active video
  } sync_t;

  typedef logic [10:0] coord_t; // screen coordinate, covers 1344 counts

  //////////////////////////////////////////////////////////////////////
  // game types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    frame_jump  = 2'd0, // also the screen-saver image
    frame_left  = 2'd1,
    frame_right = 2'd2
  } frame_t;

  typedef enum logic [1:0] {
    st_saver,   // bouncing sprite
    st_start,   // first jump in flight
    st_playing
  } game_state_t;

  // top-left corner of the sprite plus the image to show
  typedef struct packed {
    coord_t x;
    coord_t y;
    frame_t frame;
  } sprite_pos_t;

  //////////////////////////////////////////////////////////////////////
  // sprite image geometry, fixed by sprites.hex
  //////////////////////////////////////////////////////////////////////

  localparam int sprite_w      = 8;
  localparam int sprite_h      = 8;
  localparam int sprite_frames = 3;
  localparam int row_bits      = $clog2(sprite_h);
  localparam int col_bits      = $clog2(sprite_w);

  typedef logic [$bits(frame_t)+row_bits-1:0] rom_addr_t; // {frame, row}
  typedef rgb_t [0:sprite_w-1] rom_row_t; // index 0 is the leftmost pixel, first in the hex line

endpackage

//--- hdl/video_timing.sv
`timescale 1ns/1ns

module video_timing #(
  parameter int h_sync   = 136,
  parameter int h_back   = 160,
  parameter int h_active = 1024,
  parameter int h_front  = 24,
  parameter int v_sync   = 6,
  parameter int v_back   = 29,
  parameter int v_active = 768,
  parameter int v_front  = 3
) (
  input  logic                clk,
  input  logic                rst,
  output dino_pkg::sync_t     sync,      // raw, same cycle as the counters
  output dino_pkg::coord_t    x,         // active-area column
  output dino_pkg::coord_t    y,         // active-area line
  output logic                frame_stb  // first cycle of a new frame
);

  localparam int h_total = h_sync + h_back + h_active + h_front;
  localparam int v_total = v_sync + v_back + v_active + v_front;
  localparam int h_start = h_sync + h_back; // first active count
  localparam int v_start = v_sync + v_back;

  dino_pkg::coord_t h_cnt;
  dino_pkg::coord_t v_cnt;
  logic             h_last;
  logic             v_last;

  assign h_last = (h_cnt == dino_pkg::coord_t'(h_total - 1));
  assign v_last = (v_cnt == dino_pkg::coord_t'(v_total - 1));

  //////////////////////////////////////////////////////////////////////
  // pixel and line counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      h_cnt     <= '0;
      v_cnt     <= '0;
      frame_stb <= 1'b0;
    end
    else
    begin
      frame_stb <= h_last && v_last; // only on a real wrap, not out of reset
      if (h_last)
      begin
        h_cnt <= '0;
        if (v_last)
          v_cnt <= '0;
        else
          v_cnt <= v_cnt + 1'b1;
      end
      else
        h_cnt <= h_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sync, data enable and coordinates
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    sync.hs = (h_cnt >= h_sync); // low for the first h_sync counts
    sync.vs = (v_cnt >= v_sync);
    sync.de = (h_cnt >= h_start) && (h_cnt < h_start + h_active) &&
              (v_cnt >= v_start) && (v_cnt < v_start + v_active);
  end

  // garbage outside the active window, only read while de is high
  assign x = h_cnt - dino_pkg::coord_t'(h_start);
  assign y = v_cnt - dino_pkg::coord_t'(v_start);

endmodule

//--- hdl/button_conditioner.sv
`timescale 1ns/1ns

module button_conditioner #(
  parameter int debounce_cycles = 650000
) (
  input  logic clk,
  input  logic rst,
  input  logic btn,      // raw, asynchronous
  output logic jump_stb  // one cycle per clean press
);

  localparam int cnt_w = $clog2(debounce_cycles + 1);

  logic             sync0;   // metastability stage
  logic             sync1;
  logic             clean;   // debounced level
  logic             clean_q; // for edge detect
  logic [cnt_w-1:0] cnt;     // samples differing from clean

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sync0    <= 1'b0;
      sync1    <= 1'b0;
      clean    <= 1'b0;
      clean_q  <= 1'b0;
      cnt      <= '0;
      jump_stb <= 1'b0;
    end
    else
    begin
      sync0   <= btn;
      sync1   <= sync0;
      clean_q <= clean;
      if (sync1 == clean)
        cnt <= '0; // glitch over, start again
      else if (cnt == cnt_w'(debounce_cycles - 1))
      begin
        clean <= sync1; // debounce_cycles equal samples seen
        cnt   <= '0;
      end
      else
        cnt <= cnt + 1'b1;
      jump_stb <= clean && !clean_q; // rising edge only
    end
  end

endmodule

//--- hdl/dino_motion.sv
`timescale 1ns/1ns

module dino_motion #(
  parameter int h_active    = 1024,
  parameter int v_active    = 768,
  parameter int jump_frames = 64,
  parameter int jump_div    = 4,
  parameter int walk_frames = 8,
  parameter int dino_x      = 128,
  parameter int ground_y    = 600
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  frame_stb,
  input  logic                  jump_stb,
  output dino_pkg::sprite_pos_t pos
);

  localparam dino_pkg::coord_t x_max = dino_pkg::coord_t'(h_active - dino_pkg::sprite_w);
  localparam dino_pkg::coord_t y_max = dino_pkg::coord_t'(v_active - dino_pkg::sprite_h);
  localparam int step_w = $clog2(jump_frames + 1);
  localparam int walk_w = $clog2(walk_frames + 1);

  dino_pkg::game_state_t state;
  logic                  dir_x;      // 1 = moving right
  logic                  dir_y;      // 1 = moving down
  logic                  jumping;
  logic [step_w-1:0]     step;       // frames into the current jump
  logic [step_w-1:0]     step_nx;
  logic                  jump_req;   // press waiting for the next frame
  logic [walk_w-1:0]     walk_cnt;   // frames shown with the current leg
  logic                  walk_right;
  logic                  flip_x;
  logic                  flip_y;
  logic                  nd_x;
  logic                  nd_y;
  logic                  start_jump;
  logic                  end_jump;
  logic                  walk_show;  // this frame shows a walk image
  dino_pkg::coord_t      height;
  dino_pkg::frame_t      walk_frame;

  //////////////////////////////////////////////////////////////////////
  // next-frame decisions
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    step_nx = step + 1'b1;
    // parabola, zero at both ends of the jump
    height = dino_pkg::coord_t'((int'(step_nx) * (jump_frames - int'(step_nx))) / jump_div);
    end_jump = jumping && (int'(step_nx) == jump_frames);
    start_jump = (jump_req || jump_stb) &&
                 ((state == dino_pkg::st_saver) ||
                  (state == dino_pkg::st_playing && !jumping)); // presses mid-air dropped
    walk_show = !start_jump &&
                (end_jump || (state == dino_pkg::st_playing && !jumping));
    walk_frame = walk_right ? dino_pkg::frame_right : dino_pkg::frame_left;

    // screen saver bounce, flip at the edge then step away from it
    flip_x = dir_x ? (pos.x == x_max) : (pos.x == '0);
    flip_y = dir_y ? (pos.y == y_max) : (pos.y == '0);
    nd_x = dir_x ^ flip_x;
    nd_y = dir_y ^ flip_y;
  end

  //////////////////////////////////////////////////////////////////////
  // state, position and animation registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state      <= dino_pkg::st_saver;
      dir_x      <= 1'b1;
      dir_y      <= 1'b1;
      jumping    <= 1'b0;
      step       <= '0;
      jump_req   <= 1'b0;
      walk_cnt   <= '0;
      walk_right <= 1'b0; // first walk leg is left
      pos        <= '{x: '0, y: '0, frame: dino_pkg::frame_jump};
    end
    else if (frame_stb)
    begin
      jump_req <= 1'b0; // consumed or ignored here
      if (start_jump)
      begin
        jumping   <= 1'b1;
        step      <= '0;
        if (state == dino_pkg::st_saver)
          state <= dino_pkg::st_start;
        pos.x     <= dino_pkg::coord_t'(dino_x);
        pos.y     <= dino_pkg::coord_t'(ground_y); // step 0 sits on the ground
        pos.frame <= dino_pkg::frame_jump;
      end
      else if (jumping)
      begin
        step  <= step_nx;
        pos.x <= dino_pkg::coord_t'(dino_x);
        pos.y <= dino_pkg::coord_t'(ground_y) - height;
        if (end_jump)
        begin
          jumping   <= 1'b0;
          state     <= dino_pkg::st_playing; // no-op when already playing
          pos.frame <= walk_frame;
        end
        else
          pos.frame <= dino_pkg::frame_jump;
      end
      else if (state == dino_pkg::st_saver)
      begin
        dir_x <= nd_x;
        dir_y <= nd_y;
        pos.x <= nd_x ? pos.x + 1'b1 : pos.x - 1'b1;
        pos.y <= nd_y ? pos.y + 1'b1 : pos.y - 1'b1;
      end
      else
        pos.frame <= walk_frame; // on the ground, walking

      // walk legs keep their phase across jumps
      if (walk_show)
      begin
        if (walk_cnt == walk_w'(walk_frames - 1))
        begin
          walk_cnt   <= '0;
          walk_right <= !walk_right;
        end
        else
          walk_cnt <= walk_cnt + 1'b1;
      end
    end
    else if (jump_stb)
      jump_req <= 1'b1;
  end

endmodule

//--- hdl/sprite_rom.sv
`timescale 1ns/1ns

module sprite_rom (
  input  logic                clk,
  input  dino_pkg::rom_addr_t addr, // {frame, row}
  output dino_pkg::rom_row_t  row   // whole 8-pixel row, one cycle later
);

  localparam int depth = dino_pkg::sprite_frames * dino_pkg::sprite_h;

  dino_pkg::rom_row_t mem [0:depth-1];

  // frames in order jump, left, right; one row per line
  initial
  begin
    $readmemh("sprites.hex", mem);
  end

  always_ff @(posedge clk)
  begin
    row <= mem[addr]; // frame 3 never addressed
  end

endmodule

//--- hdl/sprite_renderer.sv
`timescale 1ns/1ns

module sprite_renderer (
  input  logic                  clk,
  input  logic                  rst,
  input  dino_pkg::sync_t       sync_in, // raw from the timing block
  input  dino_pkg::coord_t      x,
  input  dino_pkg::coord_t      y,
  input  dino_pkg::sprite_pos_t pos,
  output dino_pkg::sync_t       sync,    // sync_in delayed by 3
  output dino_pkg::rgb_t        rgb
);

  localparam dino_pkg::sync_t sync_idle = '{hs: 1'b1, vs: 1'b1, de: 1'b0};

  dino_pkg::coord_t               dx;       // offset into the sprite box
  dino_pkg::coord_t               dy;
  logic                           hit;
  dino_pkg::sync_t                s1_sync;
  dino_pkg::sync_t                s2_sync;
  logic                           s1_hit;
  logic                           s2_hit;
  logic [dino_pkg::col_bits-1:0]  s1_col;
  logic [dino_pkg::col_bits-1:0]  s2_col;
  dino_pkg::rom_addr_t            rom_addr;
  dino_pkg::rom_row_t             rom_row;

  //////////////////////////////////////////////////////////////////////
  // stage 1, hit test and row address
  //////////////////////////////////////////////////////////////////////

  // left of or above the sprite wraps to a large unsigned value
  assign dx = x - pos.x;
  assign dy = y - pos.y;
  assign hit = sync_in.de &&
               (dx < dino_pkg::coord_t'(dino_pkg::sprite_w)) &&
               (dy < dino_pkg::coord_t'(dino_pkg::sprite_h));

  always_ff @(posedge clk)
  begin
    s1_hit   <= hit;
    s1_col   <= dx[dino_pkg::col_bits-1:0];
    rom_addr <= {pos.frame, dy[dino_pkg::row_bits-1:0]};
  end

  sprite_rom u_rom (
    .clk  (clk),
    .addr (rom_addr),
    .row  (rom_row)   // lands with stage 2
  );

  //////////////////////////////////////////////////////////////////////
  // stage 2 waits for the row, stage 3 picks the pixel
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    s2_hit <= s1_hit;
    s2_col <= s1_col;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      s1_sync <= sync_idle;
      s2_sync <= sync_idle;
      sync    <= sync_idle;
      rgb     <= '0;
    end
    else
    begin
      s1_sync <= sync_in;
      s2_sync <= s1_sync;
      sync    <= s2_sync;
      if (!s2_sync.de)
        rgb <= '0; // blanking
      else if (s2_hit)
        rgb <= rom_row[s2_col];
      else
        rgb <= dino_pkg::white;
    end
  end

endmodule

//--- hdl/dino_top.sv
`timescale 1ns/1ns

module dino_top #(
  parameter int h_sync          = 136,
  parameter int h_back          = 160,
  parameter int h_active        = 1024,
  parameter int h_front         = 24,
  parameter int v_sync          = 6,
  parameter int v_back          = 29,
  parameter int v_active        = 768,
  parameter int v_front         = 3,
  parameter int debounce_cycles = 650000, // about 10 ms at 65 MHz
  parameter int jump_frames     = 64,
  parameter int jump_div        = 4,      // peak height 256 lines
  parameter int walk_frames     = 8,
  parameter int dino_x          = 128,
  parameter int ground_y        = 600
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            btn,
  output dino_pkg::sync_t sync,
  output dino_pkg::rgb_t  rgb
);

  dino_pkg::sync_t       sync_raw;
  dino_pkg::coord_t      x;
  dino_pkg::coord_t      y;
  logic                  frame_stb;
  logic                  jump_stb;
  dino_pkg::sprite_pos_t pos;

  video_timing #(
    .h_sync   (h_sync),
    .h_back   (h_back),
    .h_active (h_active),
    .h_front  (h_front),
    .v_sync   (v_sync),
    .v_back   (v_back),
    .v_active (v_active),
    .v_front  (v_front)
  ) u_timing (
    .clk       (clk),
    .rst       (rst),
    .sync      (sync_raw),
    .x         (x),
    .y         (y),
    .frame_stb (frame_stb)
  );

  button_conditioner #(
    .debounce_cycles (debounce_cycles)
  ) u_button (
    .clk      (clk),
    .rst      (rst),
    .btn      (btn),
    .jump_stb (jump_stb)
  );

  dino_motion #(
    .h_active    (h_active),
    .v_active    (v_active),
    .jump_frames (jump_frames),
    .jump_div    (jump_div),
    .walk_frames (walk_frames),
    .dino_x      (dino_x),
    .ground_y    (ground_y)
  ) u_motion (
    .clk       (clk),
    .rst       (rst),
    .frame_stb (frame_stb),
    .jump_stb  (jump_stb),
    .pos       (pos)        // steady through the active lines
  );

  sprite_renderer u_render (
    .clk     (clk),
    .rst     (rst),
    .sync_in (sync_raw),
    .x       (x),
    .y       (y),
    .pos     (pos),
    .sync    (sync),        // 3 cycles behind the counters
    .rgb     (rgb)
  );

endmodule

//--- verification/dino_checker.sv
`timescale 1ns/1ns

module dino_checker (
  input logic            clk,
  input logic            rst,
  input dino_pkg::sync_t sync,
  input dino_pkg::rgb_t  rgb
);

  //////////////////////////////////////////////////////////////////////
  // output raster rules
  //////////////////////////////////////////////////////////////////////

  // blanking carries no colour
  a_blank_black: assert property (
    @(posedge clk) disable iff (rst)
    !sync.de |-> (rgb == '0)
  ) else $error("rgb nonzero while de is low");

  // active video only outside both sync pulses
  a_de_outside_sync: assert property (
    @(posedge clk) disable iff (rst)
    sync.de |-> (sync.hs && sync.vs)
  ) else $error("de high during a sync pulse");

  // idle raster levels held in reset
  a_reset_idle: assert property (
    @(posedge clk)
    rst |-> (sync.hs && sync.vs && !sync.de)
  ) else $error("sync group left its reset values during reset");

  a_reset_black: assert property (
    @(posedge clk)
    rst |-> (rgb == '0)
  ) else $error("rgb nonzero during reset");

endmodule

//--- verification/dino_tb.sv
`timescale 1ns/1ns

module dino_tb;

  //////////////////////////////////////////////////////////////////////
  // small raster and game settings
  //////////////////////////////////////////////////////////////////////

  localparam int h_sync          = 4;
  localparam int h_back          = 4;
  localparam int h_active        = 48;
  localparam int h_front         = 4;
  localparam int v_sync          = 2;
  localparam int v_back          = 2;
  localparam int v_active        = 32;
  localparam int v_front         = 2;
  localparam int debounce_cycles = 8;
  localparam int jump_frames     = 16;
  localparam int jump_div        = 8;
  localparam int walk_frames     = 2;
  localparam int dino_x          = 4;
  localparam int ground_y        = 20;
  localparam int h_total         = h_sync + h_back + h_active + h_front;
  localparam int v_total         = v_sync + v_back + v_active + v_front;
  localparam int frame_cycles    = h_total * v_total;
  localparam int x_max           = h_active - 8; // right edge of the bounce
  localparam int y_max           = v_active - 8;
  localparam int n_rows          = 8;

  // one stimulus step, applied just after a vsync start
  typedef struct packed {
    logic [7:0] frames; // vsync starts to wait afterwards
    logic       level;  // button level held for the row
    logic [7:0] glitch; // cycles of a leading high pulse
  } stim_t;

  stim_t stim [0:n_rows-1] = '{
    '{frames: 8'd45, level: 1'b0, glitch: 8'd0}, // idle raster and bounce
    '{frames: 8'd3,  level: 1'b0, glitch: 8'd3}, // short pulse, filtered
    '{frames: 8'd20, level: 1'b1, glitch: 8'd0}, // first jump
    '{frames: 8'd8,  level: 1'b0, glitch: 8'd0}, // walking
    '{frames: 8'd3,  level: 1'b1, glitch: 8'd0}, // jump in play
    '{frames: 8'd2,  level: 1'b0, glitch: 8'd0},
    '{frames: 8'd14, level: 1'b1, glitch: 8'd0}, // press mid-air, ignored
    '{frames: 8'd6,  level: 1'b0, glitch: 8'd0}
  };

  logic            clk;
  logic            rst;
  logic            btn;
  dino_pkg::sync_t sync;
  dino_pkg::rgb_t  rgb;

  logic [95:0] sprite_mem [0:23]; // own copy of the image file

  // reference model of the game
  dino_pkg::game_state_t m_state;
  int   m_x;
  int   m_y;
  int   m_frame;
  int   m_dx;
  int   m_dy;
  logic m_jumping;
  int   m_step;
  int   m_walk_cnt;
  logic m_walk_right;
  logic press_pending; // press seen, applied at the next frame
  logic btn_level;

  // raster scan state
  int   frames_seen;
  int   col;
  int   line;
  logic in_line;
  logic prev_vs;
  logic found;
  int   found_x;
  int   found_y;
  int   h_pos; // raster position of the output sync
  int   v_pos;
  dino_pkg::rgb_t exp_px;

  dino_top #(
    .h_sync          (h_sync),
    .h_back          (h_back),
    .h_active        (h_active),
    .h_front         (h_front),
    .v_sync          (v_sync),
    .v_back          (v_back),
    .v_active        (v_active),
    .v_front         (v_front),
    .debounce_cycles (debounce_cycles),
    .jump_frames     (jump_frames),
    .jump_div        (jump_div),
    .walk_frames     (walk_frames),
    .dino_x          (dino_x),
    .ground_y        (ground_y)
  ) u_dut (
    .clk  (clk),
    .rst  (rst),
    .btn  (btn),
    .sync (sync),
    .rgb  (rgb)
  );

  bind dino_top dino_checker u_checker (
    .clk  (clk),
    .rst  (rst),
    .sync (sync),
    .rgb  (rgb)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic compare_rgb(input string name, input dino_pkg::rgb_t got,
                             input dino_pkg::rgb_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h (line %0d col %0d)",
               name, got, exp, line, col);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic compare_pos(input string name, input dino_pkg::coord_t got,
                             input dino_pkg::coord_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h (frame %0d)", name, got, exp, frames_seen);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic compare_sync(input string name, input dino_pkg::sync_t got,
                              input dino_pkg::sync_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h (h %0d v %0d)",
               name, got, exp, h_pos, v_pos);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string what);
    $display("ERROR %s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // expected colour of one active pixel for the current model position
  function automatic dino_pkg::rgb_t expected_pixel(input int px, input int py);
    int          dx;
    int          dy;
    logic [95:0] row;
    dx = px - m_x;
    dy = py - m_y;
    if (dx >= 0 && dx < 8 && dy >= 0 && dy < 8)
    begin
      row = sprite_mem[m_frame * 8 + dy];
      return row[95 - 12 * dx -: 12]; // leftmost pixel first in the line
    end
    return 12'hfff; // background
  endfunction

  // sync group for one position of the output raster
  function automatic dino_pkg::sync_t expected_sync(input int h, input int v);
    dino_pkg::sync_t s;
    s.hs = (h >= h_sync); // pulse at the start of each line
    s.vs = (v >= v_sync);
    s.de = (h >= h_sync + h_back) && (h < h_total - h_front) &&
           (v >= v_sync + v_back) && (v < v_total - v_front);
    return s;
  endfunction

  task automatic step_model();
    logic start;
    logic show_walk;
    int   walk_img;
    start = press_pending &&
            (m_state == dino_pkg::st_saver ||
             (m_state == dino_pkg::st_playing && !m_jumping));
    press_pending = 1'b0; // ignored presses are dropped
    walk_img = m_walk_right ? 2 : 1;
    show_walk = 1'b0;
    if (start)
    begin
      m_jumping = 1'b1;
      m_step = 0;
      if (m_state == dino_pkg::st_saver)
        m_state = dino_pkg::st_start;
      m_x = dino_x;
      m_y = ground_y;
      m_frame = 0;
    end
    else if (m_jumping)
    begin
      m_step = m_step + 1;
      m_x = dino_x;
      m_y = ground_y - (m_step * (jump_frames - m_step)) / jump_div; // parabola
      if (m_step == jump_frames)
      begin
        m_jumping = 1'b0;
        m_state = dino_pkg::st_playing;
        m_frame = walk_img;
        show_walk = 1'b1;
      end
      else
        m_frame = 0;
    end
    else if (m_state == dino_pkg::st_saver)
    begin
      if ((m_dx > 0 && m_x == x_max) || (m_dx < 0 && m_x == 0))
        m_dx = -m_dx; // bounce off left or right
      if ((m_dy > 0 && m_y == y_max) || (m_dy < 0 && m_y == 0))
        m_dy = -m_dy;
      m_x = m_x + m_dx;
      m_y = m_y + m_dy;
    end
    else
    begin
      m_frame = walk_img;
      show_walk = 1'b1;
    end
    if (show_walk)
    begin
      m_walk_cnt = m_walk_cnt + 1;
      if (m_walk_cnt == walk_frames)
      begin
        m_walk_cnt = 0;
        m_walk_right = !m_walk_right; // next leg
      end
    end
  endtask

  // whole frame seen, sprite must sit where the model put it
  task automatic check_frame_end();
    if (line != v_active)
      report_failure($sformatf("frame %0d had %0d active lines", frames_seen, line));
    if (!found)
      report_failure($sformatf("no sprite found in frame %0d", frames_seen));
    compare_pos("sprite_x", dino_pkg::coord_t'(found_x), dino_pkg::coord_t'(m_x));
    compare_pos("sprite_y", dino_pkg::coord_t'(found_y), dino_pkg::coord_t'(m_y));
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor, sampled away from the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (prev_vs && !sync.vs) // vsync start
      begin
        if (frames_seen > 0)
        begin
          check_frame_end();
          step_model(); // first frame after reset shows the reset position
        end
        else
        begin
          h_pos = 0; // lock onto the output raster
          v_pos = 0;
        end
        frames_seen = frames_seen + 1;
        line = 0;
        col = 0;
        in_line = 1'b0;
        found = 1'b0;
      end
      if (frames_seen > 0)
      begin
        compare_sync("sync", sync, expected_sync(h_pos, v_pos));
        h_pos = h_pos + 1;
        if (h_pos == h_total)
        begin
          h_pos = 0;
          v_pos = (v_pos + 1) % v_total;
        end
      end
      if (sync.de)
      begin
        exp_px = expected_pixel(col, line);
        compare_rgb("rgb", rgb, exp_px);
        if (!found && rgb != dino_pkg::white)
        begin
          found = 1'b1; // top-left pixel is never white
          found_x = col;
          found_y = line;
        end
        col = col + 1;
        in_line = 1'b1;
      end
      else
      begin
        compare_rgb("rgb", rgb, 12'h000); // blanking
        if (in_line)
        begin
          line = line + 1;
          col = 0;
          in_line = 1'b0;
        end
      end
    end
    prev_vs = sync.vs;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus and watchdog
  //////////////////////////////////////////////////////////////////////

  function automatic int total_frames();
    int n;
    n = 0;
    for (int r = 0; r < n_rows; r++)
      n = n + int'(stim[r].frames);
    return n + 2;
  endfunction

  task automatic apply_row(input stim_t s);
    if (s.glitch != 0)
    begin
      btn = 1'b1; // short spike
      repeat (int'(s.glitch)) @(negedge clk);
    end
    btn = s.level;
    if (!btn_level && (s.level || int'(s.glitch) >= debounce_cycles))
      press_pending = 1'b1; // a clean press
    btn_level = s.level;
  endtask

  initial
  begin : stimulus
    int target;
    rst = 1'b1;
    btn = 1'b0;
    btn_level = 1'b0;
    press_pending = 1'b0;
    m_state = dino_pkg::st_saver;
    m_x = 0;
    m_y = 0;
    m_frame = 0;
    m_dx = 1; // right and down
    m_dy = 1;
    m_jumping = 1'b0;
    m_step = 0;
    m_walk_cnt = 0;
    m_walk_right = 1'b0;
    frames_seen = 0;
    col = 0;
    line = 0;
    in_line = 1'b0;
    prev_vs = 1'b1;
    found = 1'b0;
    found_x = 0;
    found_y = 0;
    h_pos = 0;
    v_pos = 0;
    $readmemh("sprites.hex", sprite_mem);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    target = 1;
    for (int r = 0; r < n_rows; r++)
    begin
      wait (frames_seen >= target);
      @(negedge clk);
      apply_row(stim[r]);
      target = target + int'(stim[r].frames);
    end
    wait (frames_seen >= target);
    $display("All tests passed!");
    $finish;
  end

  initial
  begin : watchdog
    longint limit;
    limit = longint'(total_frames()) * frame_cycles * 100 * 2;
    #(limit);
    $display("ERROR timeout, the stimulus table did not finish in %0d ns", limit);
    $display("Test failures found");
    $fatal(1);
  end

endmodule

//--- sprites.hex
// one sprite row per line, eight 12-bit rgb pixels, leftmost pixel first
// rows 0-7 jump frame, 8-15 left leg up, 16-23 right leg up
cdccdccdccdc383383383cdc
cdccdccdccdc383111383383
cdccdccdccdc383383383383
383cdccdc383383383cdccdc
383383383383383383383cdc
cdc383383383383383cdccdc
cdccdc383cdc383cdccdccdc
cdccdc383cdc383cdccdccdc
cdccdccdccdc383383383cdc
cdccdccdccdc383111383383
cdccdccdccdc383383383383
383cdccdc383383383cdccdc
383383383383383383383cdc
cdc383383383383383cdccdc
cdccdc383cdc383cdccdccdc
cdccdc383cdccdccdccdccdc
cdccdccdccdc383383383cdc
cdccdccdccdc383111383383
cdccdccdccdc383383383383
383cdccdc383383383cdccdc
383383383383383383383cdc
cdc383383383383383cdccdc
cdccdc383cdc383cdccdccdc
cdccdccdccdc383cdccdccdc

//--- all.f
hdl/dino_pkg.sv
hdl/video_timing.sv
hdl/button_conditioner.sv
hdl/dino_motion.sv
hdl/sprite_rom.sv
hdl/sprite_renderer.sv
hdl/dino_top.sv
verification/dino_checker.sv
verification/dino_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module dino_tb -o dino_sim &&
./obj_dir/dino_sim || exit 1
